/* all.f */
rtl/ccc_pkg.sv
rtl/ccc_desc_reg.sv
rtl/ddr_crc5.sv
rtl/ddr_word_shifter.sv
rtl/ccc_sequencer.sv
rtl/ccc_engine_top.sv
verif/ccc_checker.sv
verif/tb_ccc_engine.sv

/* rtl/ccc_desc_reg.sv */
`timescale 1ns/1ns

module ccc_desc_reg #(
  parameter int MAX_LEN = 63
) (
  input  logic                           i_sys_clk,
  input  logic                           i_sys_rst,
  input  logic                           i_load,
  input  ccc_pkg::ccc_desc_t             i_desc_in,
  input  logic                           i_take,
  output ccc_pkg::ccc_desc_t             o_desc,
  output logic                           o_supported,
  output logic [ccc_pkg::DATA_LEN_W-1:0] o_remaining
);

  logic code_known;

  // descriptor is held for the whole frame
  always_ff @(posedge i_sys_clk) begin
    if (i_load) begin
      o_desc <= i_desc_in;
    end
  end

  // bytes still to be pulled from the host
  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_remaining <= '0;
    end else if (i_load) begin
      o_remaining <= i_desc_in.len;
    end else if (i_take && (o_remaining != '0)) begin
      o_remaining <= o_remaining - 1'b1; // one byte taken
    end
  end

  // only the listed broadcast codes, direct codes 80 and up fall to default
  always_comb begin
    case (o_desc.code)
      ccc_pkg::CCC_ENEC,
      ccc_pkg::CCC_DISEC,
      ccc_pkg::CCC_SETMWL,
      ccc_pkg::CCC_SETMRL,
      ccc_pkg::CCC_RSTACT: code_known = 1'b1;
      default:             code_known = 1'b0;
    endcase
  end

  assign o_supported = code_known && (int'(o_desc.len) <= MAX_LEN); // count limit too

endmodule

/* rtl/ccc_engine_top.sv */
`timescale 1ns/1ns

module ccc_engine_top #(
  parameter int MAX_LEN = 63
) (
  input  logic                 i_sys_clk,
  input  logic                 i_sys_rst,
  input  logic                 i_cmd_valid,
  input  ccc_pkg::ccc_desc_t   i_cmd,
  output logic                 o_cmd_ready,
  input  logic                 i_data_valid,
  input  logic [7:0]           i_data,
  output logic                 o_data_ready,
  output logic                 o_slot_valid,
  output ccc_pkg::bus_slot_t   o_slot,
  input  logic                 i_slot_ready,
  input  logic                 i_sda_in,
  output logic                 o_resp_valid,
  output ccc_pkg::ccc_status_e o_resp,
  input  logic                 i_resp_ready
);

  logic                           cmd_load;
  logic                           take;
  logic                           supported;
  ccc_pkg::ccc_desc_t             desc;
  logic [ccc_pkg::DATA_LEN_W-1:0] remaining;
  logic                           req_valid;
  ccc_pkg::word_req_t             req;
  logic                           req_ready;
  logic                           word_done;
  logic                           sample;
  logic                           crc_clr;
  logic                           crc_en;
  logic [7:0]                     crc_byte;
  logic [4:0]                     crc;

  ccc_sequencer u_seq (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_cmd_valid  (i_cmd_valid),
    .o_cmd_ready  (o_cmd_ready),
    .o_cmd_load   (cmd_load),
    .i_data_valid (i_data_valid),
    .i_data       (i_data),
    .o_data_ready (o_data_ready),
    .o_take       (take),
    .i_slot_ready (i_slot_ready),
    .i_resp_ready (i_resp_ready),
    .i_supported  (supported),
    .i_desc       (desc),
    .i_remaining  (remaining),
    .o_req_valid  (req_valid),
    .o_req        (req),
    .i_req_ready  (req_ready),
    .i_word_done  (word_done),
    .i_sample     (sample),
    .o_crc_clr    (crc_clr),
    .o_crc_en     (crc_en),
    .o_crc_byte   (crc_byte),
    .i_crc        (crc),
    .o_resp_valid (o_resp_valid),
    .o_resp       (o_resp)
  );

  ccc_desc_reg #(.MAX_LEN(MAX_LEN)) u_desc (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_load      (cmd_load),
    .i_desc_in   (i_cmd),
    .i_take      (take),
    .o_desc      (desc),
    .o_supported (supported),
    .o_remaining (remaining)
  );

  ddr_word_shifter u_shift (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_req_valid  (req_valid),
    .i_req        (req),
    .o_req_ready  (req_ready),
    .o_slot_valid (o_slot_valid),
    .o_slot       (o_slot),
    .i_slot_ready (i_slot_ready),
    .i_sda_in     (i_sda_in),
    .o_word_done  (word_done),
    .o_sample     (sample)
  );

  ddr_crc5 u_crc (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_clr     (crc_clr),
    .i_en      (crc_en),
    .i_byte    (crc_byte),
    .o_crc     (crc)
  );

endmodule

/* rtl/ccc_pkg.sv */
package ccc_pkg;

  // byte count width, 63 bytes max per frame
  localparam int DATA_LEN_W = 6;

  localparam logic [6:0] BCAST_ADDR = 7'h7E; // broadcast address of the command word
  localparam logic [3:0] CRC_TOKEN  = 4'hC;  // leads the crc word
  localparam logic [4:0] CRC_INIT   = 5'h1F; // crc-5 seed

  // broadcast ccc codes handled by the engine
  typedef enum logic [7:0] {
    CCC_ENEC   = 8'h00,
    CCC_DISEC  = 8'h01,
    CCC_SETMWL = 8'h09,
    CCC_SETMRL = 8'h0A,
    CCC_RSTACT = 8'h2A
  } ccc_code_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD_WORD,
    ST_ACK_SLOT,
    ST_CCC_WORD,
    ST_CONT_SLOT,   // continue/abort slot ahead of each data word
    ST_DATA_WORD,
    ST_CRC_WORD,
    ST_RESP
  } seq_state_e;

  // what the shifter is asked to put on the bus
  typedef enum logic [1:0] {
    WK_CMD,   // preamble 01, payload, parity
    WK_ACK,   // tx 1 then a released slot
    WK_DATA,  // payload and parity, preamble already sent
    WK_CRC    // 01, token, crc-5, 1
  } word_kind_e;

  typedef enum logic [1:0] {
    STS_OK,
    STS_NACK,
    STS_ABORTED,
    STS_UNSUPPORTED
  } ccc_status_e;

  typedef struct packed {
    logic [7:0]            code;
    logic                  dbp;       // defining byte present
    logic [7:0]            def_byte;
    logic [DATA_LEN_W-1:0] len;       // data bytes after the ccc word
  } ccc_desc_t;

  typedef struct packed {
    logic value;  // level the controller drives
    logic rx;     // line released, target bit sampled
  } bus_slot_t;

  typedef struct packed {
    word_kind_e  kind;
    logic [15:0] payload;
    logic [4:0]  crc;
  } word_req_t;

endpackage

/* rtl/ccc_sequencer.sv */
`timescale 1ns/1ns

module ccc_sequencer (
  input  logic                           i_sys_clk,
  input  logic                           i_sys_rst,
  input  logic                           i_cmd_valid,
  output logic                           o_cmd_ready,
  output logic                           o_cmd_load,
  input  logic                           i_data_valid,
  input  logic [7:0]                     i_data,
  output logic                           o_data_ready,
  output logic                           o_take,
  input  logic                           i_slot_ready,
  input  logic                           i_resp_ready,
  input  logic                           i_supported,
  input  ccc_pkg::ccc_desc_t             i_desc,
  input  logic [ccc_pkg::DATA_LEN_W-1:0] i_remaining,
  output logic                           o_req_valid,
  output ccc_pkg::word_req_t             o_req,
  input  logic                           i_req_ready,
  input  logic                           i_word_done,
  input  logic                           i_sample,
  output logic                           o_crc_clr,
  output logic                           o_crc_en,
  output logic [7:0]                     o_crc_byte,
  input  logic [4:0]                     i_crc,
  output logic                           o_resp_valid,
  output ccc_pkg::ccc_status_e           o_resp
);

  ccc_pkg::seq_state_e  state_q;
  ccc_pkg::seq_state_e  state_d;
  ccc_pkg::ccc_status_e status_q;
  ccc_pkg::ccc_status_e status_d;
  logic                 req_sent_q;   // word handed to the shifter, waiting for done
  logic                 crc_pend_q;   // low payload byte still owed to the crc
  logic [1:0]           nbytes_q;     // bytes in the holding register
  logic [7:0]           hold_hi_q;
  logic [7:0]           hold_lo_q;
  logic [15:0]          word_payload;
  logic                 word_full;
  logic                 req_want;
  logic                 req_fire;
  logic                 byte_fire;

  assign o_cmd_ready  = (state_q == ccc_pkg::ST_IDLE);  // one frame at a time
  assign o_cmd_load   = i_cmd_valid && o_cmd_ready;
  assign o_crc_clr    = o_cmd_load;
  assign o_resp_valid = (state_q == ccc_pkg::ST_RESP);
  assign o_resp       = status_q;

  // last data word may be odd, low byte then becomes padding
  assign word_full = (nbytes_q == 2'd2) || ((nbytes_q == 2'd1) && (i_remaining == '0));

  // pull bytes only while the phy is taking slots, a stalled bus leaves the host alone
  assign o_data_ready = (state_q == ccc_pkg::ST_DATA_WORD) && !req_sent_q &&
                        (nbytes_q != 2'd2) && (i_remaining != '0) && i_slot_ready;
  assign byte_fire    = o_data_ready && i_data_valid;
  assign o_take       = byte_fire;

  always_comb begin
    word_payload = '0;
    case (state_q)
      ccc_pkg::ST_CMD_WORD:  word_payload = {8'h00, ccc_pkg::BCAST_ADDR, 1'b0}; // write, 7E
      ccc_pkg::ST_CCC_WORD:  word_payload = {i_desc.code, i_desc.dbp ? i_desc.def_byte : 8'h00};
      ccc_pkg::ST_DATA_WORD: word_payload = {hold_hi_q, (nbytes_q == 2'd2) ? hold_lo_q : 8'h00};
      default:               word_payload = '0;
    endcase
  end

  always_comb begin
    o_req.kind    = ccc_pkg::WK_ACK;
    o_req.payload = word_payload;
    o_req.crc     = i_crc;          // final value by the time the crc word goes out
    req_want      = 1'b0;
    case (state_q)
      ccc_pkg::ST_CMD_WORD: begin
        o_req.kind = ccc_pkg::WK_CMD;
        req_want   = i_supported;
      end
      ccc_pkg::ST_ACK_SLOT,
      ccc_pkg::ST_CONT_SLOT: req_want = 1'b1;
      ccc_pkg::ST_CCC_WORD: begin
        o_req.kind = ccc_pkg::WK_DATA;
        req_want   = 1'b1;
      end
      ccc_pkg::ST_DATA_WORD: begin
        o_req.kind = ccc_pkg::WK_DATA;
        req_want   = word_full;     // both bytes in before any payload slot
      end
      ccc_pkg::ST_CRC_WORD: begin
        o_req.kind = ccc_pkg::WK_CRC;
        req_want   = 1'b1;
      end
      default: req_want = 1'b0;
    endcase
  end

  assign o_req_valid = req_want && !req_sent_q;
  assign req_fire    = o_req_valid && i_req_ready;

  // high byte on the request, low byte the cycle after
  assign o_crc_en   = crc_pend_q || (req_fire && (o_req.kind == ccc_pkg::WK_DATA));
  assign o_crc_byte = crc_pend_q ? word_payload[7:0] : word_payload[15:8];

  always_comb begin
    state_d  = state_q;
    status_d = status_q;
    case (state_q)
      ccc_pkg::ST_IDLE: if (o_cmd_load) state_d = ccc_pkg::ST_CMD_WORD;
      ccc_pkg::ST_CMD_WORD: begin
        if (!i_supported) begin
          status_d = ccc_pkg::STS_UNSUPPORTED; // no slots at all
          state_d  = ccc_pkg::ST_RESP;
        end else if (i_word_done) begin
          state_d = ccc_pkg::ST_ACK_SLOT;
        end
      end
      ccc_pkg::ST_ACK_SLOT: begin
        if (i_word_done && i_sample) begin
          status_d = ccc_pkg::STS_NACK;        // target held the line high
          state_d  = ccc_pkg::ST_RESP;
        end else if (i_word_done) begin
          state_d = ccc_pkg::ST_CCC_WORD;
        end
      end
      ccc_pkg::ST_CCC_WORD,
      ccc_pkg::ST_DATA_WORD: begin
        if (i_word_done) begin
          state_d = (i_remaining != '0) ? ccc_pkg::ST_CONT_SLOT : ccc_pkg::ST_CRC_WORD;
        end
      end
      ccc_pkg::ST_CONT_SLOT: begin
        if (i_word_done && !i_sample) begin
          status_d = ccc_pkg::STS_ABORTED;     // target pulled low, no crc word
          state_d  = ccc_pkg::ST_RESP;
        end else if (i_word_done) begin
          state_d = ccc_pkg::ST_DATA_WORD;
        end
      end
      ccc_pkg::ST_CRC_WORD: begin
        if (i_word_done) begin
          status_d = ccc_pkg::STS_OK;
          state_d  = ccc_pkg::ST_RESP;
        end
      end
      ccc_pkg::ST_RESP: if (i_resp_ready) state_d = ccc_pkg::ST_IDLE;
      default: state_d = ccc_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q    <= ccc_pkg::ST_IDLE;
      status_q   <= ccc_pkg::STS_OK;
      req_sent_q <= 1'b0;
      crc_pend_q <= 1'b0;
      nbytes_q   <= '0;
    end else begin
      state_q    <= state_d;
      status_q   <= status_d;
      crc_pend_q <= req_fire && (o_req.kind == ccc_pkg::WK_DATA);
      if (i_word_done) begin
        req_sent_q <= 1'b0;
        nbytes_q   <= '0;        // holding register free for the next word
      end else begin
        if (req_fire) req_sent_q <= 1'b1;
        if (byte_fire) nbytes_q <= nbytes_q + 1'b1;
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (byte_fire && (nbytes_q == 2'd0)) begin
      hold_hi_q <= i_data;  // first byte of the word
    end
    if (byte_fire && (nbytes_q == 2'd1)) begin
      hold_lo_q <= i_data;
    end
  end

endmodule

/* rtl/ddr_crc5.sv */
`timescale 1ns/1ns

module ddr_crc5 (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_clr,
  input  logic       i_en,
  input  logic [7:0] i_byte,
  output logic [4:0] o_crc
);

  // x^5 + x^2 + 1, one byte msb first
  function automatic logic [4:0] crc5_byte(input logic [4:0] crc_in, input logic [7:0] data);
    logic [4:0] crc;
    logic       fb;
    crc = crc_in;
    for (int i = 7; i >= 0; i--) begin
      fb  = crc[4] ^ data[i];            // feedback from the top bit
      crc = {crc[3:0], 1'b0};
      if (fb) begin
        crc = crc ^ 5'b00101;            // taps at x^2 and x^0
      end
    end
    return crc;
  endfunction

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_crc <= ccc_pkg::CRC_INIT;
    end else if (i_clr) begin
      o_crc <= ccc_pkg::CRC_INIT; // new frame
    end else if (i_en) begin
      o_crc <= crc5_byte(o_crc, i_byte);
    end
  end

endmodule

/* rtl/ddr_word_shifter.sv */
`timescale 1ns/1ns

module ddr_word_shifter (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst,
  input  logic               i_req_valid,
  input  ccc_pkg::word_req_t i_req,
  output logic               o_req_ready,
  output logic               o_slot_valid,
  output ccc_pkg::bus_slot_t o_slot,
  input  logic               i_slot_ready,
  input  logic               i_sda_in,
  output logic               o_word_done,
  output logic               o_sample
);

  logic [19:0] pat_q;      // slot pattern, msb goes out first
  logic [19:0] pat_d;
  logic [4:0]  cnt_q;      // slots left in the word
  logic [4:0]  len_d;
  logic        rx_word_q;  // ack type word, last slot is released
  logic        par_p1;
  logic        par_p0;
  logic        load;
  logic        slot_fire;
  logic        rx_slot;

  // hdr-ddr parity, p1 over odd payload bits, p0 over even bits inverted
  assign par_p1 = ^(i_req.payload & 16'hAAAA);
  assign par_p0 = ~^(i_req.payload & 16'h5555);

  always_comb begin
    pat_d = '0;
    len_d = '0;
    case (i_req.kind)
      ccc_pkg::WK_CMD: begin
        pat_d = {2'b01, i_req.payload, par_p1, par_p0};
        len_d = 5'd20;
      end
      ccc_pkg::WK_ACK: begin
        pat_d = {2'b11, 18'b0};  // second slot floats high for the target
        len_d = 5'd2;
      end
      ccc_pkg::WK_DATA: begin
        pat_d = {i_req.payload, par_p1, par_p0, 2'b00};
        len_d = 5'd18;
      end
      ccc_pkg::WK_CRC: begin
        pat_d = {2'b01, ccc_pkg::CRC_TOKEN, i_req.crc, 1'b1, 8'b0};
        len_d = 5'd12;
      end
      default: begin
        pat_d = '0;
        len_d = '0;
      end
    endcase
  end

  assign o_req_ready  = (cnt_q == 5'd0);         // idle between words
  assign load         = i_req_valid && o_req_ready;
  assign o_slot_valid = (cnt_q != 5'd0);
  assign slot_fire    = o_slot_valid && i_slot_ready;
  assign rx_slot      = rx_word_q && (cnt_q == 5'd1);
  assign o_slot       = '{value: pat_q[19], rx: rx_slot};

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      cnt_q       <= '0;
      rx_word_q   <= 1'b0;
      o_word_done <= 1'b0;
    end else begin
      o_word_done <= slot_fire && (cnt_q == 5'd1); // pulse after the last slot
      if (load) begin
        cnt_q     <= len_d;
        rx_word_q <= (i_req.kind == ccc_pkg::WK_ACK);
      end else if (slot_fire) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (load) begin
      pat_q <= pat_d;
    end else if (slot_fire) begin
      pat_q <= {pat_q[18:0], 1'b0};  // next slot to the top
    end
    if (slot_fire && rx_slot) begin
      o_sample <= i_sda_in;          // target bit
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the ccc engine testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_ccc_engine -o sim_ccc \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_ccc)
echo "$out"
echo "$out" | grep -q "All tests passed!" && exit 0 || exit 1

/* verif/ccc_checker.sv */
`timescale 1ns/1ns

module ccc_checker #(
  parameter int MAX_LEN = 63
) (
  input  logic                 i_sys_clk,
  input  logic                 i_sys_rst,
  input  logic                 i_cmd_valid,
  input  ccc_pkg::ccc_desc_t   i_cmd,
  input  logic                 i_cmd_ready,
  input  logic                 i_data_valid,
  input  logic [7:0]           i_data,
  input  logic                 i_data_ready,
  input  logic                 i_slot_valid,
  input  ccc_pkg::bus_slot_t   i_slot,
  input  logic                 i_slot_ready,
  input  logic                 i_sda_in,
  input  logic                 i_resp_valid,
  input  ccc_pkg::ccc_status_e i_resp,
  input  logic                 i_resp_ready,
  input  logic                 i_end,
  output int                   o_errors
);

  localparam int NW_NONE = 0, NW_CCC = 1, NW_CONT = 2, NW_DATA = 3, NW_CRC = 4;

  ccc_pkg::bus_slot_t   exp_q[$];   // expected slots of the word in flight
  logic [7:0]           byte_q[$];  // bytes handed over and not yet framed
  ccc_pkg::ccc_desc_t   desc;
  ccc_pkg::ccc_status_e exp_sts;
  ccc_pkg::bus_slot_t   got;
  ccc_pkg::bus_slot_t   want;
  logic [4:0]           crc;
  int                   next_w;
  int                   rem;
  int                   cyc;        // cycles since accept
  logic                 open;
  logic                 first_seen;
  logic                 rx_is_ack;
  logic                 end_done;
  int                   errors = 0;

  assign o_errors = errors;

  // crc-5 with x^5+x^2+1 taken msb first
  function automatic logic [4:0] crc_step(input logic [4:0] c, input logic [7:0] b);
    logic [4:0] r;
    logic       top;
    r = c;
    for (int k = 7; k >= 0; k--) begin
      top = r[4] ^ b[k];
      r   = {r[3:0], 1'b0} ^ ({5{top}} & 5'b00101);
    end
    return r;
  endfunction

  task automatic push_slot(input logic v, input logic rx);
    ccc_pkg::bus_slot_t s;
    s.value = v;
    s.rx    = rx;
    exp_q.push_back(s);
  endtask

  task automatic push_word(input logic [15:0] p, input logic pre);
    logic p1;
    logic p0;
    p1 = 1'b0;
    p0 = 1'b1;   // p0 inverted
    if (pre) begin
      push_slot(1'b0, 1'b0);
      push_slot(1'b1, 1'b0);
    end
    for (int k = 15; k >= 0; k--) begin
      push_slot(p[k], 1'b0);
      if (k % 2 == 1) p1 = p1 ^ p[k]; // odd bits
      else p0 = p0 ^ p[k];
    end
    push_slot(p1, 1'b0);
    push_slot(p0, 1'b0);
  endtask

  task automatic gen_next();
    logic [7:0] hi;
    logic [7:0] lo;
    case (next_w)
      NW_CCC: begin
        hi = desc.code;
        lo = desc.dbp ? desc.def_byte : 8'h00;
        crc = crc_step(crc_step(crc, hi), lo);
        push_word({hi, lo}, 1'b0);
        next_w = (rem > 0) ? NW_CONT : NW_CRC;
      end
      NW_CONT: begin
        push_slot(1'b1, 1'b0);
        push_slot(1'b1, 1'b1);   // released for the target
        rx_is_ack = 1'b0;
        next_w = NW_NONE;
      end
      NW_DATA: begin
        if (byte_q.size() < ((rem >= 2) ? 2 : 1)) begin
          $display("error at %0t: data word started before its bytes were taken", $time);
          errors++;
        end
        hi = (byte_q.size() > 0) ? byte_q.pop_front() : 8'h00;
        lo = 8'h00;            // padding for an odd count
        if (rem >= 2) begin
          lo  = (byte_q.size() > 0) ? byte_q.pop_front() : 8'h00;
          rem = rem - 2;
        end else begin
          rem = 0;
        end
        crc = crc_step(crc_step(crc, hi), lo);
        push_word({hi, lo}, 1'b0);
        next_w = (rem > 0) ? NW_CONT : NW_CRC;
      end
      NW_CRC: begin
        push_slot(1'b0, 1'b0);
        push_slot(1'b1, 1'b0);
        for (int k = 3; k >= 0; k--) push_slot(ccc_pkg::CRC_TOKEN[k], 1'b0);
        for (int k = 4; k >= 0; k--) push_slot(crc[k], 1'b0);
        push_slot(1'b1, 1'b0);
        exp_sts = ccc_pkg::STS_OK;
        next_w  = NW_NONE;
      end
      default: ;
    endcase
  endtask

  always @(posedge i_sys_clk) begin
    if (i_sys_rst) begin
      if (open) cyc++;
      if (open && !first_seen && (i_slot_valid || i_resp_valid)) begin
        first_seen = 1'b1;
        if (cyc != 2) begin
          $display("MISMATCH @%0t: first slot or response %0d cycles after accept", $time, cyc);
          errors++;
        end
      end
      if (i_data_valid && i_data_ready) byte_q.push_back(i_data);
      if (i_slot_valid && i_slot_ready) begin
        got = i_slot;
        if (exp_q.size() == 0) gen_next();
        if (exp_q.size() == 0) begin
          $display("MISMATCH @%0t: slot %b outside any expected word", $time, got);
          errors++;
        end else begin
          want = exp_q.pop_front();
          if (got != want) begin
            $display("MISMATCH @%0t: slot value/rx %b, expected %b", $time, got, want);
            errors++;
          end
          if (want.rx && rx_is_ack) begin
            if (i_sda_in) begin
              exp_sts = ccc_pkg::STS_NACK; // frame ends here
              next_w  = NW_NONE;
            end else begin
              next_w = NW_CCC;
            end
          end else if (want.rx) begin
            if (!i_sda_in) begin
              exp_sts = ccc_pkg::STS_ABORTED;
              next_w  = NW_NONE;
            end else begin
              next_w = NW_DATA;
            end
          end
        end
      end
      if (i_resp_valid && i_resp_ready) begin
        if (!open) begin
          $display("error at %0t: response arrived without a frame", $time);
          errors++;
        end else begin
          if (i_resp != exp_sts) begin
            $display("MISMATCH @%0t: status %s, expected %s", $time, i_resp.name(),
                     exp_sts.name());
            errors++;
          end
          if (exp_q.size() != 0 || next_w != NW_NONE) begin
            $display("MISMATCH @%0t: response before the frame was complete", $time);
            errors++;
          end
        end
        open = 1'b0;
      end
      if (i_cmd_valid && i_cmd_ready) begin
        if (open) begin
          $display("error at %0t: descriptor accepted while a frame was open", $time);
          errors++;
        end
        desc       = i_cmd;
        open       = 1'b1;
        first_seen = 1'b0;
        cyc        = 0;
        crc        = ccc_pkg::CRC_INIT;
        rem        = int'(i_cmd.len);
        next_w     = NW_NONE;
        exp_q.delete();
        byte_q.delete();
        if ((i_cmd.code == ccc_pkg::CCC_ENEC || i_cmd.code == ccc_pkg::CCC_DISEC ||
             i_cmd.code == ccc_pkg::CCC_SETMWL || i_cmd.code == ccc_pkg::CCC_SETMRL ||
             i_cmd.code == ccc_pkg::CCC_RSTACT) && rem <= MAX_LEN) begin
          push_word({1'b0, 7'h00, ccc_pkg::BCAST_ADDR, 1'b0}, 1'b1); // rnw 0 and seven zeros
          push_slot(1'b1, 1'b0);
          push_slot(1'b1, 1'b1);
          rx_is_ack = 1'b1;
        end else begin
          exp_sts = ccc_pkg::STS_UNSUPPORTED; // no slots at all
        end
      end
      if (i_end && !end_done) begin
        end_done = 1'b1;
        if (open) begin
          $display("error: a frame was still open when the run ended");
          errors++;
        end
      end
    end else begin
      open     = 1'b0;
      end_done = 1'b0;
    end
  end

endmodule

/* verif/tb_ccc_engine.sv */
`timescale 1ns/1ns

module tb_ccc_engine;

  localparam int  N_ENTRIES = 12;
  localparam int  MAX_LEN   = 16;
  localparam time WATCHDOG  = N_ENTRIES * 60 * 4 * 40; // entries x slots x cycles x period

  typedef struct packed {
    logic [7:0]           code;
    logic                 dbp;
    logic [7:0]           def_byte;
    logic [5:0]           len;
    logic                 ack_bit;   // 1 means the target nacks
    logic [7:0]           abort_at;  // data word index that aborts or ff for none
    ccc_pkg::ccc_status_e exp;
  } entry_t;

  logic                 i_sys_clk = 1'b0;
  logic                 i_sys_rst;
  logic                 i_cmd_valid;
  ccc_pkg::ccc_desc_t   i_cmd;
  logic                 o_cmd_ready;
  logic                 i_data_valid;
  logic [7:0]           i_data;
  logic                 o_data_ready;
  logic                 o_slot_valid;
  ccc_pkg::bus_slot_t   o_slot;
  logic                 i_slot_ready;
  logic                 i_sda_in;
  logic                 o_resp_valid;
  ccc_pkg::ccc_status_e o_resp;
  logic                 i_resp_ready;
  logic                 run_end;
  entry_t               table_e[N_ENTRIES];
  int                   cur = 0;         // entry of the frame in flight
  int                   pres = 0;        // entry offered on the descriptor channel
  int                   rx_cnt = 0;      // rx slots taken in this frame
  logic                 data_fire_q = 1'b0;
  int                   seed = 27;
  int                   errs = 0;
  int                   chk_errs;

  always #20 i_sys_clk = ~i_sys_clk;

  ccc_engine_top #(.MAX_LEN(MAX_LEN)) dut (
    .i_sys_clk(i_sys_clk), .i_sys_rst(i_sys_rst),
    .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .o_cmd_ready(o_cmd_ready),
    .i_data_valid(i_data_valid), .i_data(i_data), .o_data_ready(o_data_ready),
    .o_slot_valid(o_slot_valid), .o_slot(o_slot), .i_slot_ready(i_slot_ready),
    .i_sda_in(i_sda_in),
    .o_resp_valid(o_resp_valid), .o_resp(o_resp), .i_resp_ready(i_resp_ready)
  );

  ccc_checker #(.MAX_LEN(MAX_LEN)) chk (
    .i_sys_clk(i_sys_clk), .i_sys_rst(i_sys_rst),
    .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .i_cmd_ready(o_cmd_ready),
    .i_data_valid(i_data_valid), .i_data(i_data), .i_data_ready(o_data_ready),
    .i_slot_valid(o_slot_valid), .i_slot(o_slot), .i_slot_ready(i_slot_ready),
    .i_sda_in(i_sda_in),
    .i_resp_valid(o_resp_valid), .i_resp(o_resp), .i_resp_ready(i_resp_ready),
    .i_end(run_end), .o_errors(chk_errs)
  );

  // target bit for the current rx slot with the ack first and then continue slots
  function automatic logic target_bit();
    if (rx_cnt == 0) return table_e[cur].ack_bit;
    return ((rx_cnt - 1) == int'(table_e[cur].abort_at)) ? 1'b0 : 1'b1;
  endfunction

  task automatic drive_descriptor(input int idx);
    pres        = idx;
    i_cmd       = '{code: table_e[idx].code, dbp: table_e[idx].dbp,
                    def_byte: table_e[idx].def_byte, len: table_e[idx].len};
    i_cmd_valid = 1'b1;
  endtask

  always @(posedge i_sys_clk) begin
    data_fire_q <= i_data_valid && o_data_ready;
    if (i_cmd_valid && o_cmd_ready) begin
      rx_cnt <= 0;
      cur    <= pres;   // new frame starts
    end else if (o_slot_valid && i_slot_ready && o_slot.rx) begin
      rx_cnt <= rx_cnt + 1;
    end
  end

  // host data source, phy back-pressure and target on the falling edge
  initial begin
    i_data_valid = 1'b0;
    i_data       = 8'h00;
    i_slot_ready = 1'b0;
    i_resp_ready = 1'b0;
    i_sda_in     = 1'b1;
    forever begin
      @(negedge i_sys_clk);
      if (data_fire_q || !i_data_valid) begin  // hold an offered byte until taken
        i_data_valid = ($random(seed) & 3) != 0;
        i_data       = 8'($random(seed));
      end
      i_slot_ready = ($random(seed) & 3) != 0;
      i_resp_ready = ($random(seed) & 1) != 0;
      i_sda_in     = target_bit();
    end
  end

  initial begin
    #(WATCHDOG);
    run_end = 1'b1;   // checker flags a frame left open
    repeat (2) @(posedge i_sys_clk);
    $display("timeout: the run did not finish within %0t", WATCHDOG);
    $display("Test failures found");
    $finish;
  end

  initial begin
    table_e[0]  = '{8'h00, 1'b0, 8'h00, 6'd0,  1'b0, 8'hFF, ccc_pkg::STS_OK};
    table_e[1]  = '{8'h09, 1'b1, 8'h5A, 6'd0,  1'b0, 8'hFF, ccc_pkg::STS_OK};
    table_e[2]  = '{8'h01, 1'b0, 8'h00, 6'd3,  1'b0, 8'hFF, ccc_pkg::STS_OK};
    table_e[3]  = '{8'h0A, 1'b1, 8'h33, 6'd4,  1'b0, 8'hFF, ccc_pkg::STS_OK};
    table_e[4]  = '{8'h2A, 1'b1, 8'h81, 6'd9,  1'b0, 8'hFF, ccc_pkg::STS_OK};
    table_e[5]  = '{8'h00, 1'b0, 8'h00, 6'd2,  1'b1, 8'hFF, ccc_pkg::STS_NACK};
    table_e[6]  = '{8'h01, 1'b1, 8'hC3, 6'd6,  1'b0, 8'h01, ccc_pkg::STS_ABORTED};
    table_e[7]  = '{8'h09, 1'b0, 8'h00, 6'd1,  1'b0, 8'h00, ccc_pkg::STS_ABORTED};
    table_e[8]  = '{8'h80, 1'b1, 8'h11, 6'd0,  1'b0, 8'hFF, ccc_pkg::STS_UNSUPPORTED};
    table_e[9]  = '{8'h05, 1'b0, 8'h00, 6'd2,  1'b0, 8'hFF, ccc_pkg::STS_UNSUPPORTED};
    table_e[10] = '{8'h00, 1'b0, 8'h00, 6'd20, 1'b0, 8'hFF, ccc_pkg::STS_UNSUPPORTED};
    table_e[11] = '{8'h0A, 1'b0, 8'h00, 6'd15, 1'b0, 8'hFF, ccc_pkg::STS_OK};
    i_sys_rst   = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd       = '0;
    run_end     = 1'b0;
    repeat (3) @(posedge i_sys_clk);
    @(negedge i_sys_clk);
    i_sys_rst = 1'b1;
    @(negedge i_sys_clk);
    if (!o_cmd_ready || o_slot_valid || o_data_ready || o_resp_valid) begin
      $display("MISMATCH @%0t: control outputs wrong after reset", $time);
      errs++;
    end
    @(negedge i_sys_clk);
    drive_descriptor(0);
    for (int i = 0; i < N_ENTRIES; i++) begin
      @(posedge i_sys_clk);
      while (!o_cmd_ready) @(posedge i_sys_clk);   // entry i taken on this edge
      @(negedge i_sys_clk);
      if (i + 1 < N_ENTRIES) begin
        drive_descriptor(i + 1);   // next descriptor waits while this frame runs
      end else begin
        i_cmd_valid = 1'b0;
      end
      @(posedge i_sys_clk);
      while (!(o_resp_valid && i_resp_ready)) @(posedge i_sys_clk);
      if (o_resp != table_e[i].exp) begin
        $display("MISMATCH @%0t: entry %0d status %s, expected %s", $time, i,
                 o_resp.name(), table_e[i].exp.name());
        errs++;
      end
    end
    @(negedge i_sys_clk);
    run_end = 1'b1;
    repeat (2) @(posedge i_sys_clk);
    $display("testbench errors: %0d, checker errors: %0d", errs, chk_errs);
    if (errs + chk_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
